//--- logic/video_pkg.sv
// Shared frame sizes, CPU bus types and palette encodings for the colour output stage
// Import with a wildcard in the module header of any block that needs these
package video_pkg;

    // Frame geometry in pixels and lines
    localparam int H_TOTAL  = 64;
    localparam int H_ACTIVE = 48;
    localparam int V_TOTAL  = 40;
    localparam int V_ACTIVE = 32;
    localparam int H_W      = $clog2(H_TOTAL);
    localparam int V_W      = $clog2(V_TOTAL);

    // Palette RAM is 4096 bytes, entries are 10 bits wide once the half and bank bits are taken
    localparam int PAL_AW  = 12;
    localparam int PAL_EW  = PAL_AW - 2;
    // CPU address bit that steers an access to the control register
    localparam int CFG_SEL = 11;

    // CPU port FSM states
    localparam logic [1:0] PS_IDLE   = 2'd0;
    localparam logic [1:0] PS_ACCESS = 2'd1;
    localparam logic [1:0] PS_WAIT   = 2'd2;
    localparam logic [1:0] PS_ACK    = 2'd3;

    typedef struct packed {
        logic [PAL_AW-1:0] addr;
        logic [7:0]        wdata;
        logic              we;
    } cpu_req_t;

    // First field is the upper bit, so video_en lands in register bit 0
    typedef struct packed {
        logic pal_bank;
        logic video_en;
    } video_ctrl_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // Even bytes carry red in the low nibble, odd bytes carry green and blue
    typedef union packed {
        struct packed {logic [3:0] unused; logic [3:0] red;} red_v;
        struct packed {logic [3:0] green; logic [3:0] blue;} gb_v;
    } pal_byte_u;

endpackage

//--- logic/video_timing.sv
// Raster timing for the video board
// Makes the pixel clock enable and the registered horizontal and vertical blanking flags
`timescale 1ns/1ps

module video_timing
    import video_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    output logic pxl_cen,
    output logic lhbl,
    output logic lvbl
);

    logic [H_W-1:0] hcnt;
    logic [V_W-1:0] vcnt;
    logic [H_W-1:0] hcnt_nx;
    logic [V_W-1:0] vcnt_nx;
    logic           h_wrap;
    logic           v_wrap;

    // Counters wrap at the last pixel of a line and the last line of a frame
    assign h_wrap  = hcnt == H_W'(H_TOTAL - 1);
    assign v_wrap  = vcnt == V_W'(V_TOTAL - 1);
    assign hcnt_nx = h_wrap ? '0 : hcnt + 1'b1;

    always_comb begin
        vcnt_nx = vcnt;
        // The line count only moves when the line ends
        if (h_wrap) begin
            vcnt_nx = v_wrap ? '0 : vcnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pxl_cen <= 1'b0;
            hcnt    <= '0;
            vcnt    <= '0;
            lhbl    <= 1'b0;
            lvbl    <= 1'b0;
        end else begin
            // Pixel rate is half the system clock
            pxl_cen <= ~pxl_cen;
            if (pxl_cen) begin
                hcnt <= hcnt_nx;
                vcnt <= vcnt_nx;
                // Flags follow the new counts, so they settle the cycle after the enable
                lhbl <= hcnt_nx < H_W'(H_ACTIVE);
                lvbl <= vcnt_nx < V_W'(V_ACTIVE);
            end
        end
    end

endmodule

//--- logic/palette_port.sv
// CPU side of the palette, a four-phase req/ack slave with the video control register
// Bank mapping and write gating are applied here before the RAM
`timescale 1ns/1ps

module palette_port
    import video_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  cpu_req_t          cpu,
    input  logic [7:0]        ram_q,
    output logic              ack,
    output logic [7:0]        rdata,
    output video_ctrl_t       ctrl,
    output logic [PAL_AW-1:0] ram_addr,
    output logic [7:0]        ram_wdata,
    output logic              ram_we
);

    logic [1:0] state;
    logic       is_cfg;

    assign is_cfg = cpu.addr[CFG_SEL];
    assign ack    = state == PS_ACK;

    // Byte address bit 0 picks the half, so red and green/blue sit in separate RAM halves
    assign ram_addr  = {cpu.addr[0], ctrl.pal_bank, cpu.addr[PAL_EW:1]};
    assign ram_wdata = cpu.wdata;
    // Palette writes are dropped while the mixer owns the colours
    assign ram_we    = (state == PS_ACCESS) && cpu.we && !is_cfg && !ctrl.video_en;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= PS_IDLE;
            ctrl  <= '0;
        end else begin
            case (state)
                PS_IDLE: if (req) state <= PS_ACCESS;
                PS_ACCESS: begin
                    // The RAM sees the access on this edge
                    if (cpu.we && is_cfg) ctrl <= video_ctrl_t'(cpu.wdata[1:0]);
                    state <= PS_WAIT;
                end
                PS_WAIT: state <= PS_ACK;
                // Ack stays up as long as the CPU keeps req high
                default: if (!req) state <= PS_IDLE;
            endcase
        end
    end

    // Read data is caught as ack rises and held while it stays high
    always_ff @(posedge clk) begin
        if (state == PS_WAIT) begin
            rdata <= is_cfg ? {6'd0, ctrl} : ram_q;
        end
    end

endmodule

//--- logic/palette_ram.sv
// Dual-port palette memory, 4096 bytes
// Port A serves the CPU with read and write, port B is the read-only video fetch
`timescale 1ns/1ps

module palette_ram
    import video_pkg::*;
(
    input  logic              clk,
    input  logic [PAL_AW-1:0] a_addr,
    input  logic [7:0]        a_wdata,
    input  logic              a_we,
    input  logic [PAL_AW-1:0] b_addr,
    output logic [7:0]        a_q,
    output logic [7:0]        b_q
);

    logic [7:0] mem [0:(2**PAL_AW)-1];

    // CPU port, read data shows the old contents on a write
    always_ff @(posedge clk) begin
        if (a_we) begin
            mem[a_addr] <= a_wdata;
        end
        a_q <= mem[a_addr];
    end

    // Video port, one cycle from address to data
    always_ff @(posedge clk) begin
        b_q <= mem[b_addr];
    end

endmodule

//--- logic/colour_mixer.sv
// Layer priority and palette lookup for each pixel
// Fetches red then green/blue on the two cycles of a pixel and registers blanked 12-bit RGB
`timescale 1ns/1ps

module colour_mixer
    import video_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pxl_cen,
    input  logic              lhbl,
    input  logic              lvbl,
    input  video_ctrl_t       ctrl,
    input  logic [7:0]        obj_pxl,
    input  logic [10:0]       ch_pxl,
    input  logic [7:0]        pal_q,
    output logic [PAL_AW-1:0] pal_addr,
    output rgb_t              rgb
);

    logic              obj_opaque;
    logic              ch_opaque;
    logic [PAL_EW-1:0] sel_idx;
    logic [PAL_EW-1:0] idx_r;
    logic              half;
    logic              blank_r;
    logic [3:0]        red_r;
    pal_byte_u         pal_b;

    // A low nibble of all ones is the transparent code in both layers
    assign obj_opaque = ~&obj_pxl[3:0];
    assign ch_opaque  = ~&ch_pxl[3:0];

    // Objects sit above characters, and with both clear the backdrop is entry 0
    // The top character bit picked the bank on the old board; pal_bank takes that role
    always_comb begin
        if (obj_opaque) begin
            sel_idx = PAL_EW'(obj_pxl);
        end else if (ch_opaque) begin
            sel_idx = ch_pxl[PAL_EW-1:0];
        end else begin
            sel_idx = '0;
        end
    end

    // The red byte is fetched straight from the inputs on the enable cycle,
    // green/blue one cycle later from the held index
    assign pal_addr = {half, ctrl.pal_bank, half ? idx_r : sel_idx};
    assign pal_b    = pal_q;

    // Half is high exactly on the second cycle of each pixel
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            half    <= 1'b0;
            blank_r <= 1'b1;
            rgb     <= '0;
        end else begin
            half <= pxl_cen;
            if (pxl_cen) begin
                // Output the pixel sampled one enable ago, then sample the new state
                rgb     <= blank_r ? rgb_t'('0) :
                           {red_r, pal_b.gb_v.green, pal_b.gb_v.blue};
                blank_r <= !lhbl || !lvbl || !ctrl.video_en;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            idx_r <= sel_idx;
        end
        // Red data arrives while half is high
        if (half) begin
            red_r <= pal_b.red_v.red;
        end
    end

endmodule

//--- logic/video_top.sv
// Top of the colour output stage
// Joins raster timing, the CPU palette port, the palette RAM and the colour mixer
`timescale 1ns/1ps

module video_top
    import video_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req,
    input  cpu_req_t    cpu,
    input  logic [7:0]  obj_pxl,
    input  logic [10:0] ch_pxl,
    output logic        ack,
    output logic [7:0]  rdata,
    output logic        pxl_cen,
    output logic        lhbl,
    output logic        lvbl,
    output rgb_t        rgb
);

    video_ctrl_t       ctrl;
    logic [PAL_AW-1:0] cpu_addr;
    logic [7:0]        cpu_wdata;
    logic              cpu_we;
    logic [7:0]        cpu_q;
    logic [PAL_AW-1:0] vid_addr;
    logic [7:0]        vid_q;

    video_timing timing_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .lhbl    (lhbl),
        .lvbl    (lvbl)
    );

    // The control register steers both the write gating here and the mixer below
    palette_port port_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .cpu       (cpu),
        .ram_q     (cpu_q),
        .ack       (ack),
        .rdata     (rdata),
        .ctrl      (ctrl),
        .ram_addr  (cpu_addr),
        .ram_wdata (cpu_wdata),
        .ram_we    (cpu_we)
    );

    palette_ram ram_i (
        .clk     (clk),
        .a_addr  (cpu_addr),
        .a_wdata (cpu_wdata),
        .a_we    (cpu_we),
        .b_addr  (vid_addr),
        .a_q     (cpu_q),
        .b_q     (vid_q)
    );

    colour_mixer mixer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .ctrl     (ctrl),
        .obj_pxl  (obj_pxl),
        .ch_pxl   (ch_pxl),
        .pal_q    (vid_q),
        .pal_addr (vid_addr),
        .rgb      (rgb)
    );

endmodule

//--- dv/clk_gen.sv
// Clock and reset source for the testbench
// Makes a 4 ns clock and holds rst_n low for the first 8 rising edges
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Release lands just after an edge, like every other driven input
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

//--- dv/video_tb.sv
// Testbench for the colour output stage
// Drives CPU palette accesses and random layer codes, checks rgb against a colour model
`timescale 1ns/1ps

module video_tb
    import video_pkg::*;
();

    // Roughly seven frames of 5120 cycles covers the palette fill and the video phases
    localparam int CYCLE_LIMIT = 40000;
    localparam int FRAME_PXLS  = H_TOTAL * V_TOTAL;

    logic        clk;
    logic        rst_n;
    logic        req;
    cpu_req_t    cpu;
    logic [7:0]  obj_pxl;
    logic [10:0] ch_pxl;
    logic        ack;
    logic [7:0]  rdata;
    logic        pxl_cen;
    logic        lhbl;
    logic        lvbl;
    rgb_t        rgb;

    // Model palette indexed by bank and CPU byte address, plus the model control bits
    logic [7:0]  model_pal [0:1][0:2047];
    logic        m_en;
    logic        m_bank;
    logic        tb_cen;
    int          m_h;
    int          m_v;
    logic        m_live;
    rgb_t        e_next;
    rgb_t        e_cur;
    logic        v_next;
    logic        v_cur;
    logic        chk_en;
    logic        rd_check;
    logic [7:0]  exp_rdata;
    string       test_name;
    int          cycles = 0;

    clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

    video_top dut_i (
        .clk(clk), .rst_n(rst_n), .req(req), .cpu(cpu),
        .obj_pxl(obj_pxl), .ch_pxl(ch_pxl), .ack(ack), .rdata(rdata),
        .pxl_cen(pxl_cen), .lhbl(lhbl), .lvbl(lvbl), .rgb(rgb)
    );

    task automatic fail_run(input string text);
        $display("%s", text);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] actv);
        fail_run($sformatf("** Error %s: expected %0h actual %0h", name, expv, actv));
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Runs one four-phase access and keeps req up for hold extra cycles once ack is seen
    task automatic cpu_access(input logic [11:0] addr, input logic [7:0] wdata,
                              input logic we, input logic [7:0] exp_q, input int hold);
        exp_rdata = exp_q;
        rd_check  = !we;
        cpu       = {addr, wdata, we};
        req       = 1'b1;
        do wait_cycles(1); while (!ack);
        if (hold > 0) wait_cycles(hold);
        req = 1'b0;
        do wait_cycles(1); while (ack);
        rd_check = 1'b0;
    endtask

    // Register writes always land while palette writes only land with video off
    task automatic cpu_write(input logic [11:0] addr, input logic [7:0] data);
        cpu_access(addr, data, 1'b1, 8'h00, 0);
        if (addr[CFG_SEL]) begin
            m_en   = data[0];
            m_bank = data[1];
        end else if (!m_en) begin
            model_pal[m_bank][addr[10:0]] = data;
        end
    endtask

    task automatic cpu_read(input logic [11:0] addr, input int hold);
        logic [7:0] exp_q;
        exp_q = addr[CFG_SEL] ? {6'd0, m_bank, m_en} : model_pal[m_bank][addr[10:0]];
        cpu_access(addr, 8'h00, 1'b0, exp_q, hold);
    endtask

    // The model bits change after the access ends, so pixels around the write go unchecked
    task automatic set_ctrl(input logic en, input logic bank);
        chk_en = 1'b0;
        cpu_write(12'h800, {6'd0, bank, en});
        wait_cycles(4);
        chk_en = 1'b1;
    endtask

    // Object code wins when opaque, then the character code, else the backdrop entry 0
    function automatic rgb_t pixel_colour(input logic [7:0] obj, input logic [10:0] ch,
                                          input logic blank);
        logic [9:0] idx;
        logic [7:0] red_byte;
        logic [7:0] gb_byte;
        if (obj[3:0] != 4'hf) idx = {2'b00, obj};
        else if (ch[3:0] != 4'hf) idx = ch[9:0];
        else idx = '0;
        red_byte = model_pal[m_bank][{idx, 1'b0}];
        gb_byte  = model_pal[m_bank][{idx, 1'b1}];
        if (blank) return '0;
        return rgb_t'({red_byte[3:0], gb_byte});
    endfunction

    // Stands in for the tile and sprite engines and forces a quarter of each layer clear
    always @(posedge clk) begin
        #1;
        obj_pxl = 8'($urandom);
        ch_pxl  = 11'($urandom);
        if ($urandom_range(3) == 0) obj_pxl[3:0] = 4'hf;
        if ($urandom_range(3) == 0) ch_pxl[3:0] = 4'hf;
    end

    // The raster and colour model keeps the expected value two enables behind the pixel
    always @(posedge clk) begin
        if (!rst_n) begin
            tb_cen <= 1'b0;
            m_h    <= 0;
            m_v    <= 0;
            m_live <= 1'b0;
            e_next <= '0;
            e_cur  <= '0;
            v_next <= 1'b0;
            v_cur  <= 1'b0;
        end else begin
            tb_cen <= !tb_cen;
            if (tb_cen) begin
                e_cur  <= e_next;
                v_cur  <= v_next;
                e_next <= pixel_colour(obj_pxl, ch_pxl,
                                       !(m_live && m_h < H_ACTIVE && m_v < V_ACTIVE) || !m_en);
                v_next <= chk_en;
                m_live <= 1'b1;
                m_h    <= (m_h == H_TOTAL - 1) ? 0 : m_h + 1;
                if (m_h == H_TOTAL - 1) m_v <= (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) fail_run("Timeout, the tests did not finish in time");
    end

    a_cen: assert property (@(posedge clk) disable iff (!rst_n) pxl_cen == tb_cen)
        else report_mismatch("pixel_enable", 32'($sampled(tb_cen)), 32'($sampled(pxl_cen)));
    a_blank: assert property (@(posedge clk) disable iff (!rst_n)
        {lhbl, lvbl} == {m_live && m_h < H_ACTIVE, m_live && m_v < V_ACTIVE})
        else report_mismatch("blanking", 32'({$sampled(m_live && m_h < H_ACTIVE),
                             $sampled(m_live && m_v < V_ACTIVE)}),
                             32'($sampled({lhbl, lvbl})));
    a_rgb: assert property (@(posedge clk) disable iff (!rst_n) tb_cen && v_cur |-> rgb == e_cur)
        else report_mismatch(test_name, 32'($sampled(e_cur)), 32'($sampled(rgb)));
    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        ack && rd_check |-> rdata == exp_rdata)
        else report_mismatch(test_name, 32'($sampled(exp_rdata)), 32'($sampled(rdata)));

    // Ack comes up on the third edge that sees req, then follows req down one edge later
    a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) == ($past(req) && $past(req, 2) && $past(req, 3) && !$past(req, 4)))
        else fail_run("ack did not rise exactly 2 cycles after req");
    a_ack_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !$past(req) && !$past(ack) |-> !ack)
        else fail_run("ack rose while req was low");
    a_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
        $past(ack) && $past(req) |-> ack)
        else fail_run("ack dropped while req was still held high");
    a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $past(ack) && !$past(req) |-> !ack)
        else fail_run("ack did not fall 1 cycle after req fell");

    initial begin
        logic [11:0] gate_addr;
        void'($urandom(32'hceca71f7));
        req       = 1'b0;
        cpu       = '0;
        obj_pxl   = '0;
        ch_pxl    = '0;
        chk_en    = 1'b0;
        rd_check  = 1'b0;
        exp_rdata = '0;
        m_en      = 1'b0;
        m_bank    = 1'b0;
        test_name = "reset";
        wait (rst_n);
        wait_cycles(2);
        // Every control value is written with junk above bit 1 and read back with longer holds
        test_name = "ctrl_reg";
        for (int v = 0; v < 4; v++) begin
            cpu_write(12'h800, (8'($urandom) & 8'hfc) | 8'(v));
            cpu_read(12'h800, v);
        end
        // Both banks filled while video is off, so every pixel must be black
        test_name = "palette_rw";
        for (int b = 0; b < 2; b++) begin
            set_ctrl(1'b0, b[0]);
            for (int a = 0; a < 2048; a++) cpu_write(12'(a), 8'($urandom));
        end
        for (int b = 0; b < 2; b++) begin
            set_ctrl(1'b0, b[0]);
            for (int i = 0; i < 128; i++) cpu_read({1'b0, 11'($urandom)}, 0);
        end
        test_name = "write_gate";
        set_ctrl(1'b1, 1'b0);
        for (int i = 0; i < 16; i++) begin
            gate_addr = {1'b0, 11'($urandom)};
            cpu_write(gate_addr, ~model_pal[0][gate_addr[10:0]]);
            cpu_read(gate_addr, 0);
        end
        test_name = "colour_bank0";
        wait_cycles(2 * FRAME_PXLS);
        test_name = "colour_bank1";
        set_ctrl(1'b1, 1'b1);
        wait_cycles(2 * FRAME_PXLS);
        test_name = "video_off";
        set_ctrl(1'b0, 1'b1);
        wait_cycles(400);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- flist.f
logic/video_pkg.sv
logic/video_timing.sv
logic/palette_port.sv
logic/palette_ram.sv
logic/colour_mixer.sv
logic/video_top.sv
dv/clk_gen.sv
dv/video_tb.sv

//--- Makefile
# Verilator build and run for the colour output stage testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := video_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_TEXT := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The log decides the result, so a run that stops early fails the grep
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
